// File: verilog.f
+incdir+.
zx_glue_pkg.sv
io_port_decoder.sv
bus_read_mux.sv
audio_clock_enables.sv
line_int_select.sv
zx_io_glue.sv
tb_clock_gen.sv
tb_zx_io_glue.sv

// File: Bender.yml
package:
  name: zx_io_glue

sources:
  - include_dirs:
      - .
    files:
      - zx_glue_pkg.sv
      - io_port_decoder.sv
      - bus_read_mux.sv
      - audio_clock_enables.sv
      - line_int_select.sv
      - zx_io_glue.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_zx_io_glue.sv

// File: tb_zx_io_glue.sv
`include "zx_glue_params.svh"

module tb_zx_io_glue;

  // five tests of at most 2000 cycles each, plus reset and margin
  localparam int TIMEOUT_CYCLES = 5 * 2000 + 2000;

  logic clk_28mhz;
  logic rst_por;
  logic rst_force;
  logic rst;

  zx_glue_pkg::z80_bus_t       bus;
  logic                        csrom;
  logic [7:0]                  rom_data;
  zx_glue_pkg::rd_source_t     ram_rd;
  zx_glue_pkg::rd_source_t     zifi_rd;
  zx_glue_pkg::rd_source_t     gs_rd;
  zx_glue_pkg::rd_source_t     fdc_rd;
  zx_glue_pkg::rd_source_t     ports_rd;
  logic                        intack;
  logic [7:0]                  im2vect;
  logic                        ts_sel;
  logic [7:0]                  ts_do0;
  logic [7:0]                  ts_do1;
  logic                        ftint;
  logic                        vdac2_sel;
  logic                        line_start;
  logic [7:0]                  cpu_din;
  zx_glue_pkg::sound_strobes_t strobes;
  zx_glue_pkg::ula_out_t       ula;
  logic                        ce_ym;
  logic                        ce_14m;
  logic                        int_start_lin;

  // reference model state
  zx_glue_pkg::ula_out_t m_ula;
  logic [1:0]            m_ft_hist;
  logic                  m_ft_pulse;

  int cycle_count  = 0;
  int error_count  = 0;
  int check_count  = 0;
  int failed_tests = 0;

  assign rst = rst_por || rst_force;

  tb_clock_gen clock_gen (
    .clk_28mhz (clk_28mhz),
    .rst       (rst_por)
  );

  zx_io_glue UUT (
    .clk_28mhz     (clk_28mhz),
    .rst           (rst),
    .bus           (bus),
    .csrom         (csrom),
    .rom_data      (rom_data),
    .ram_rd        (ram_rd),
    .zifi_rd       (zifi_rd),
    .gs_rd         (gs_rd),
    .fdc_rd        (fdc_rd),
    .ports_rd      (ports_rd),
    .intack        (intack),
    .im2vect       (im2vect),
    .ts_sel        (ts_sel),
    .ts_do0        (ts_do0),
    .ts_do1        (ts_do1),
    .ftint         (ftint),
    .vdac2_sel     (vdac2_sel),
    .line_start    (line_start),
    .cpu_din       (cpu_din),
    .strobes       (strobes),
    .ula           (ula),
    .ce_ym         (ce_ym),
    .ce_14m        (ce_14m),
    .int_start_lin (int_start_lin)
  );

  // registered part of the model, inputs are stable at the edge
  always @(posedge clk_28mhz) begin
    if (rst) begin
      m_ula      <= '0;
      m_ft_hist  <= 2'b00;
      m_ft_pulse <= 1'b0;
    end else begin
      if (!bus.iorq_n && !bus.wr_n && (bus.addr[7:0] == `ZX_PORT_ULA)) begin
        m_ula <= zx_glue_pkg::ula_out_t'(bus.dout[4:0]);
      end
      // falling edge seen at the previous edge shows up now
      m_ft_pulse <= m_ft_hist[1] && !m_ft_hist[0];
      m_ft_hist  <= {m_ft_hist[0], ftint};
    end
  end

  always @(posedge clk_28mhz) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    int errs;
    errs = error_count - errors_before;
    if (errs != 0) begin
      failed_tests++;
    end
    $display("test %s finished with %0d errors", name, errs);
  endtask

  function automatic logic chance(input int pct);
    return ($urandom() % 100) < pct;
  endfunction

  // random bus cycle, low address byte pulled toward one port
  function automatic zx_glue_pkg::z80_bus_t random_bus(input logic [7:0] hot_lo,
                                                       input int hot_pct);
    zx_glue_pkg::z80_bus_t b;
    b.addr = 16'($urandom());
    if (chance(hot_pct)) begin
      b.addr[7:0] = hot_lo;
    end
    b.dout   = 8'($urandom());
    b.iorq_n = chance(50);
    b.mreq_n = chance(50);
    b.rd_n   = chance(50);
    b.wr_n   = chance(50);
    b.m1_n   = chance(70);
    return b;
  endfunction

  function automatic zx_glue_pkg::rd_source_t random_source(input int pct);
    zx_glue_pkg::rd_source_t s;
    s.en   = chance(pct);
    s.data = 8'($urandom());
    return s;
  endfunction

  // sound port decode from the port map
  function automatic zx_glue_pkg::sound_strobes_t decode_strobes(
      input zx_glue_pkg::z80_bus_t b);
    zx_glue_pkg::sound_strobes_t s;
    logic ay;
    ay         = (b.addr[7:0] == `ZX_PORT_AY) && b.addr[15];
    s.ay_bc1   = ay && b.m1_n && !b.iorq_n && b.addr[14];
    s.ay_bdir  = ay && b.m1_n && !b.iorq_n && !b.wr_n;
    s.ts_rd_en = ay && !b.iorq_n && !b.rd_n;
    s.saa_wr   = !b.iorq_n && !b.wr_n && (b.addr[7:0] == `ZX_PORT_SAA);
    return s;
  endfunction

  task automatic drive_idle();
    bus        = '{addr: 16'h0000, dout: 8'h00, iorq_n: 1'b1, mreq_n: 1'b1,
                   rd_n: 1'b1, wr_n: 1'b1, m1_n: 1'b1};
    csrom      = 1'b0;
    rom_data   = 8'h00;
    ram_rd     = '0;
    zifi_rd    = '0;
    gs_rd      = '0;
    fdc_rd     = '0;
    ports_rd   = '0;
    intack     = 1'b0;
    im2vect    = 8'h00;
    ts_sel     = 1'b0;
    ts_do0     = 8'h00;
    ts_do1     = 8'h00;
    ftint      = 1'b1;
    vdac2_sel  = 1'b0;
    line_start = 1'b0;
  endtask

  task automatic test_ula_latch();
    int errs0;
    errs0 = error_count;
    for (int i = 0; i < 600; i++) begin
      @(posedge clk_28mhz);
      #1;
      bus = random_bus(`ZX_PORT_ULA, 60);
      @(negedge clk_28mhz);
      check_value("ula", ula, m_ula);
    end
    // one reset cycle in the middle of traffic
    @(posedge clk_28mhz);
    #1;
    rst_force = 1'b1;
    @(posedge clk_28mhz);
    #1;
    rst_force = 1'b0;
    @(negedge clk_28mhz);
    check_value("ula", ula, 32'h0);
    report_test("ula latch", errs0);
  endtask

  task automatic test_port_decode();
    int                          errs0;
    logic [7:0]                  lo;
    zx_glue_pkg::sound_strobes_t exp;
    errs0 = error_count;
    for (int i = 0; i < 600; i++) begin
      @(posedge clk_28mhz);
      #1;
      case ($urandom() % 3)
        0: lo = `ZX_PORT_AY;
        1: lo = `ZX_PORT_SAA;
        default: lo = `ZX_PORT_ULA;
      endcase
      bus    = random_bus(lo, 70);
      ts_sel = chance(50);
      ts_do0 = 8'($urandom());
      ts_do1 = 8'($urandom());
      @(negedge clk_28mhz);
      exp = decode_strobes(bus);
      check_value("ay_bdir", strobes.ay_bdir, exp.ay_bdir);
      check_value("ay_bc1", strobes.ay_bc1, exp.ay_bc1);
      check_value("saa_wr", strobes.saa_wr, exp.saa_wr);
      check_value("ts_rd_en", strobes.ts_rd_en, exp.ts_rd_en);
      check_value("ts_data", UUT.ts_data, ts_sel ? ts_do1 : ts_do0);
    end
    report_test("port decode", errs0);
  endtask

  task automatic test_read_mux();
    int                          errs0;
    logic                        en [8];
    logic [7:0]                  data [8];
    logic [7:0]                  expected;
    logic                        found;
    zx_glue_pkg::sound_strobes_t s;
    errs0 = error_count;
    for (int i = 0; i < 600; i++) begin
      @(posedge clk_28mhz);
      #1;
      bus      = random_bus(`ZX_PORT_AY, 30);
      csrom    = chance(50);
      rom_data = 8'($urandom());
      ram_rd   = random_source(10);
      zifi_rd  = random_source(10);
      gs_rd    = random_source(10);
      fdc_rd   = random_source(10);
      ports_rd = random_source(10);
      intack   = chance(10);
      im2vect  = 8'($urandom());
      ts_sel   = chance(50);
      ts_do0   = 8'($urandom());
      ts_do1   = 8'($urandom());
      @(negedge clk_28mhz);
      s       = decode_strobes(bus);
      // priority order, highest first
      en[0]   = csrom && !bus.mreq_n && !bus.rd_n;
      data[0] = rom_data;
      en[1]   = ram_rd.en;
      data[1] = ram_rd.data;
      en[2]   = s.ts_rd_en;
      data[2] = ts_sel ? ts_do1 : ts_do0;
      en[3]   = zifi_rd.en;
      data[3] = zifi_rd.data;
      en[4]   = gs_rd.en;
      data[4] = gs_rd.data;
      en[5]   = fdc_rd.en;
      data[5] = fdc_rd.data;
      en[6]   = ports_rd.en;
      data[6] = ports_rd.data;
      en[7]   = intack;
      data[7] = im2vect;
      expected = 8'hFF;
      found    = 1'b0;
      for (int k = 0; k < 8; k++) begin
        if (en[k] && !found) begin
          expected = data[k];
          found    = 1'b1;
        end
      end
      check_value("cpu_din", cpu_din, expected);
    end
    report_test("read mux", errs0);
  endtask

  task automatic test_clock_enables();
    int errs0;
    errs0 = error_count;
    @(posedge clk_28mhz);
    #1;
    drive_idle();
    rst_force = 1'b1;
    repeat (3) @(posedge clk_28mhz);
    #1;
    rst_force = 1'b0;
    // still the values left by reset
    @(negedge clk_28mhz);
    check_value("ce_ym", ce_ym, 32'h0);
    check_value("ce_14m", ce_14m, 32'h0);
    check_value("ula", ula, 32'h0);
    for (int k = 0; k < 64; k++) begin
      @(negedge clk_28mhz);
      check_value("ce_ym", ce_ym, (k % 16) == 0);
      check_value("ce_14m", ce_14m, (k % 2) == 1);
    end
    report_test("clock enables", errs0);
  endtask

  task automatic test_line_int();
    int errs0;
    errs0 = error_count;
    @(posedge clk_28mhz);
    #1;
    vdac2_sel = chance(50);
    for (int i = 0; i < 800; i++) begin
      @(posedge clk_28mhz);
      #1;
      if (chance(30)) begin
        ftint = !ftint;
      end
      // long stretches on each interrupt source
      if (chance(5)) begin
        vdac2_sel = !vdac2_sel;
      end
      line_start = chance(20);
      @(negedge clk_28mhz);
      check_value("int_start_lin", int_start_lin, vdac2_sel ? m_ft_pulse : line_start);
    end
    report_test("line interrupt", errs0);
  endtask

  initial begin
    void'($urandom(53));
    rst_force = 1'b0;
    drive_idle();
    wait (rst_por === 1'b0);
    test_ula_latch();
    test_port_decode();
    test_read_mux();
    test_clock_enables();
    test_line_int();
    $display("summary: 5 tests, %0d failed, %0d checks, %0d errors",
             failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen (
  output logic clk_28mhz,
  output logic rst
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk_28mhz = 1'b0;
    forever #HALF_PERIOD clk_28mhz = ~clk_28mhz;
  end

  // reset released just after an edge, like any other input
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_28mhz);
    #1;
    rst = 1'b0;
  end

endmodule

// File: zx_io_glue.sv
`include "zx_glue_params.svh"

module zx_io_glue (
  input  logic                        clk_28mhz,
  input  logic                        rst,
  input  zx_glue_pkg::z80_bus_t       bus,
  input  logic                        csrom,
  input  logic [7:0]                  rom_data,
  input  zx_glue_pkg::rd_source_t     ram_rd,
  input  zx_glue_pkg::rd_source_t     zifi_rd,
  input  zx_glue_pkg::rd_source_t     gs_rd,
  input  zx_glue_pkg::rd_source_t     fdc_rd,
  input  zx_glue_pkg::rd_source_t     ports_rd,
  input  logic                        intack,
  input  logic [7:0]                  im2vect,
  input  logic                        ts_sel,
  input  logic [7:0]                  ts_do0,
  input  logic [7:0]                  ts_do1,
  input  logic                        ftint,
  input  logic                        vdac2_sel,
  input  logic                        line_start,
  output logic [7:0]                  cpu_din,
  output zx_glue_pkg::sound_strobes_t strobes,
  output zx_glue_pkg::ula_out_t       ula,
  output logic                        ce_ym,
  output logic                        ce_14m,
  output logic                        int_start_lin
);

  logic                                         rom_rd_en;
  logic [7:0]                                   ts_data;
  zx_glue_pkg::rd_source_t [`ZX_RD_SOURCES-1:0] rd_sources;

  io_port_decoder u_io_port_decoder (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .bus       (bus),
    .csrom     (csrom),
    .ts_sel    (ts_sel),
    .ts_do0    (ts_do0),
    .ts_do1    (ts_do1),
    .rom_rd_en (rom_rd_en),
    .ts_data   (ts_data),
    .strobes   (strobes),
    .ula       (ula)
  );

  // read priority, rom first, interrupt vector last
  assign rd_sources[0] = zx_glue_pkg::rd_source_t'{en: rom_rd_en, data: rom_data};
  assign rd_sources[1] = ram_rd;
  assign rd_sources[2] = zx_glue_pkg::rd_source_t'{en: strobes.ts_rd_en, data: ts_data};
  assign rd_sources[3] = zifi_rd;
  assign rd_sources[4] = gs_rd;
  assign rd_sources[5] = fdc_rd;
  assign rd_sources[6] = ports_rd;
  assign rd_sources[7] = zx_glue_pkg::rd_source_t'{en: intack, data: im2vect};

  bus_read_mux u_bus_read_mux (
    .sources (rd_sources),
    .cpu_din (cpu_din)
  );

  audio_clock_enables u_audio_clock_enables (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .ce_ym     (ce_ym),
    .ce_14m    (ce_14m)
  );

  line_int_select u_line_int_select (
    .clk_28mhz     (clk_28mhz),
    .rst           (rst),
    .ftint         (ftint),
    .vdac2_sel     (vdac2_sel),
    .line_start    (line_start),
    .int_start_lin (int_start_lin)
  );

endmodule

// File: line_int_select.sv
module line_int_select (
  input  logic clk_28mhz,
  input  logic rst,
  input  logic ftint,
  input  logic vdac2_sel,
  input  logic line_start,
  output logic int_start_lin
);

  logic [1:0] ftint_sync;
  logic       ft_fall;
  logic       ft_pulse;

  // FT812 interrupt is asynchronous to the bus clock
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      ftint_sync <= 2'b00;
    end else begin
      ftint_sync <= {ftint_sync[0], ftint};
    end
  end

  // older sample high, newer low
  assign ft_fall = ftint_sync[1] && !ftint_sync[0];

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      ft_pulse <= 1'b0;
    end else begin
      ft_pulse <= ft_fall;
    end
  end

  // second video DAC takes over the line interrupt
  assign int_start_lin = vdac2_sel ? ft_pulse : line_start;

  // one interrupt request per falling edge
  property p_pulse_single;
    @(posedge clk_28mhz) disable iff (rst)
      ft_pulse |=> !ft_pulse;
  endproperty

  a_pulse_single: assert property (p_pulse_single)
    else $error("FT812 edge pulse longer than one cycle");

endmodule

// File: audio_clock_enables.sv
`include "zx_glue_params.svh"

module audio_clock_enables (
  input  logic clk_28mhz,
  input  logic rst,
  output logic ce_ym,
  output logic ce_14m
);

  logic [`ZX_YM_DIV_BITS-1:0] div;

  // free running divider, phase fixed by reset
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      div <= '0;
    end else begin
      div <= div + 1'b1;
    end
  end

  // 1.75 MHz strobe for the YM chips
  // 14 MHz enable is the divider lsb, one cycle late, so it starts low
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      ce_ym  <= 1'b0;
      ce_14m <= 1'b0;
    end else begin
      ce_ym  <= (div == '0);
      ce_14m <= div[0];
    end
  end

  // ym enable is a single-cycle strobe
  property p_ym_single;
    @(posedge clk_28mhz) disable iff (rst)
      ce_ym |=> !ce_ym;
  endproperty

  a_ym_single: assert property (p_ym_single)
    else $error("ce_ym high two cycles running");

endmodule

// File: bus_read_mux.sv
`include "zx_glue_params.svh"

module bus_read_mux (
  input  zx_glue_pkg::rd_source_t [`ZX_RD_SOURCES-1:0] sources,
  output logic [7:0]                                   cpu_din
);

  logic [7:0] sel_data;

  // index 0 wins, so walk from the bottom of the priority list upward
  // and let each enabled source overwrite the previous pick
  always_comb begin
    // idle bus reads as pulled up
    sel_data = `ZX_BUS_IDLE;
    for (int i = `ZX_RD_SOURCES - 1; i >= 0; i--) begin
      if (sources[i].en) begin
        sel_data = sources[i].data;
      end
    end
  end

  assign cpu_din = sel_data;

endmodule

// File: io_port_decoder.sv
`include "zx_glue_params.svh"

module io_port_decoder (
  input  logic                        clk_28mhz,
  input  logic                        rst,
  input  zx_glue_pkg::z80_bus_t       bus,
  input  logic                        csrom,
  input  logic                        ts_sel,
  input  logic [7:0]                  ts_do0,
  input  logic [7:0]                  ts_do1,
  output logic                        rom_rd_en,
  output logic [7:0]                  ts_data,
  output zx_glue_pkg::sound_strobes_t strobes,
  output zx_glue_pkg::ula_out_t       ula
);

  logic [7:0] addr_lo;
  logic       io_wr;
  logic       io_rd;
  logic       ay_hit;
  logic       fe_wr;

  assign addr_lo = bus.addr[7:0];

  // plain io cycles, no M1 qualification here
  assign io_wr = !bus.iorq_n && !bus.wr_n;
  assign io_rd = !bus.iorq_n && !bus.rd_n;

  // rom only answers memory reads
  assign rom_rd_en = csrom && !bus.mreq_n && !bus.rd_n;

  // #FFFD and #BFFD, A15 set, A14 picks address or data
  assign ay_hit = (addr_lo == `ZX_PORT_AY) && bus.addr[15];

  always_comb begin
    strobes = '0;
    // m1_n keeps the interrupt acknowledge cycle away from the chip
    strobes.ay_bc1   = ay_hit && bus.m1_n && !bus.iorq_n && bus.addr[14];
    strobes.ay_bdir  = ay_hit && bus.m1_n && io_wr;
    strobes.ts_rd_en = ay_hit && io_rd;
    strobes.saa_wr   = io_wr && (addr_lo == `ZX_PORT_SAA);
  end

  // the TurboSound core reports which of its two chips is selected
  assign ts_data = ts_sel ? ts_do1 : ts_do0;

  assign fe_wr = io_wr && (addr_lo == `ZX_PORT_ULA);

  // port #FE latch, only bits 4:0 are kept
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      ula <= '0;
    end else if (fe_wr) begin
      ula <= zx_glue_pkg::ula_out_t'(bus.dout[4:0]);
    end
  end

  // an AY write must always come from an io cycle
  property p_bdir_in_io;
    @(posedge clk_28mhz) disable iff (rst)
      strobes.ay_bdir |-> !bus.iorq_n;
  endproperty

  a_bdir_in_io: assert property (p_bdir_in_io)
    else $error("ay_bdir outside an io cycle");

  // ULA and SAA ports must never decode on the same cycle
  property p_fe_saa_excl;
    @(posedge clk_28mhz) disable iff (rst)
      !(fe_wr && strobes.saa_wr);
  endproperty

  a_fe_saa_excl: assert property (p_fe_saa_excl)
    else $error("#FE write and saa_wr overlap");

endmodule

// File: zx_glue_pkg.sv
package zx_glue_pkg;

  // Z80 bus as seen by the glue, strobes active low
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  dout;
    logic        iorq_n;
    logic        mreq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
  } z80_bus_t;

  // one qualified read source
  typedef struct packed {
    logic       en;
    logic [7:0] data;
  } rd_source_t;

  // latched fields of port #FE, same bit layout as the port
  typedef struct packed {
    logic       speaker;
    logic       tape_out;
    logic [2:0] border;
  } ula_out_t;

  // sound chip strobes, all active high
  typedef struct packed {
    logic ay_bdir;
    logic ay_bc1;
    logic saa_wr;
    logic ts_rd_en;
  } sound_strobes_t;

endpackage

// File: zx_glue_params.svh
`ifndef ZX_GLUE_PARAMS_SVH
`define ZX_GLUE_PARAMS_SVH

// low address byte of the ULA port (beeper, tape out, border)
`define ZX_PORT_ULA 8'hFE

// low address byte of the TurboSound port, needs A15 too
`define ZX_PORT_AY 8'hFD

// low address byte of the SAA1099 port
`define ZX_PORT_SAA 8'hFF

// YM divider width, one enable every 16 clocks at 28 MHz
`define ZX_YM_DIV_BITS 4

// what the CPU reads when nobody drives the bus
`define ZX_BUS_IDLE 8'hFF

// number of read sources in the CPU data mux
`define ZX_RD_SOURCES 8

`endif
